// File: include/soc_settings.svh
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Region select from address bits 31 to 28
`define SOC_REGION_RAM   4'h0
`define SOC_REGION_GPIO  4'h1
`define SOC_REGION_TIMER 4'h2

// RAM depth in 32-bit words
`define SOC_RAM_WORDS 1024

`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_DECERR 2'b11

// Timer register map
`define TIMER_CTRL   12'h000
`define TIMER_LIMIT  12'h004
`define TIMER_COUNT  12'h008
`define TIMER_STATUS 12'h00C

`endif

// File: design/soc_pkg.sv
package soc_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [11:0] periph_addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  resp_t;

    // Target of a routed access
    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_GPIO,
        SEL_TIMER,
        SEL_NONE
    } slave_sel_t;

    // One per channel direction
    typedef enum logic {
        RESP_IDLE,
        RESP_PEND
    } resp_state_t;

endpackage

// File: design/axi_interconnect.sv
`include "soc_settings.svh"

module axi_interconnect (
    input  logic clk,
    input  logic rst_n,

    input  soc_pkg::addr_t s_awaddr,
    input  logic           s_awvalid,
    output logic           s_awready,
    input  soc_pkg::data_t s_wdata,
    input  soc_pkg::strb_t s_wstrb,
    input  logic           s_wvalid,
    output logic           s_wready,
    output soc_pkg::resp_t s_bresp,
    output logic           s_bvalid,
    input  logic           s_bready,
    input  soc_pkg::addr_t s_araddr,
    input  logic           s_arvalid,
    output logic           s_arready,
    output soc_pkg::data_t s_rdata,
    output soc_pkg::resp_t s_rresp,
    output logic           s_rvalid,
    input  logic           s_rready,

    // RAM
    output soc_pkg::periph_addr_t ram_awaddr, ram_araddr,
    output soc_pkg::data_t        ram_wdata,
    output soc_pkg::strb_t        ram_wstrb,
    output logic                  ram_awvalid, ram_wvalid, ram_bready, ram_arvalid, ram_rready,
    input  logic                  ram_awready, ram_wready, ram_bvalid, ram_arready, ram_rvalid,
    input  soc_pkg::data_t        ram_rdata,

    // GPIO
    output soc_pkg::periph_addr_t gpio_awaddr, gpio_araddr,
    output soc_pkg::data_t        gpio_wdata,
    output soc_pkg::strb_t        gpio_wstrb,
    output logic                  gpio_awvalid, gpio_wvalid, gpio_bready, gpio_arvalid, gpio_rready,
    input  logic                  gpio_awready, gpio_wready, gpio_bvalid, gpio_arready, gpio_rvalid,
    input  soc_pkg::data_t        gpio_rdata,

    // Timer
    output soc_pkg::periph_addr_t timer_awaddr, timer_araddr,
    output soc_pkg::data_t        timer_wdata,
    output soc_pkg::strb_t        timer_wstrb,
    output logic                  timer_awvalid, timer_wvalid, timer_bready,
    output logic                  timer_arvalid, timer_rready,
    input  logic                  timer_awready, timer_wready, timer_bvalid,
    input  logic                  timer_arready, timer_rvalid,
    input  soc_pkg::data_t        timer_rdata
);

    soc_pkg::slave_sel_t  w_sel, w_sel_q, r_sel, r_sel_q;
    soc_pkg::resp_state_t w_state, r_state;
    logic                 w_idle, r_idle;

    function automatic soc_pkg::slave_sel_t decode(input soc_pkg::addr_t addr);
        case (addr[31:28])
            `SOC_REGION_RAM:   return soc_pkg::SEL_RAM;
            `SOC_REGION_GPIO:  return soc_pkg::SEL_GPIO;
            `SOC_REGION_TIMER: return soc_pkg::SEL_TIMER;
            default:           return soc_pkg::SEL_NONE;
        endcase
    endfunction

    assign w_sel  = decode(s_awaddr);
    assign r_sel  = decode(s_araddr);
    assign w_idle = (w_state == soc_pkg::RESP_IDLE);
    assign r_idle = (r_state == soc_pkg::RESP_IDLE);

    // ==========================================================
    // Request payload broadcast and valids gated by region
    // ==========================================================
    assign ram_awaddr   = s_awaddr[11:0];
    assign gpio_awaddr  = s_awaddr[11:0];
    assign timer_awaddr = s_awaddr[11:0];
    assign ram_araddr   = s_araddr[11:0];
    assign gpio_araddr  = s_araddr[11:0];
    assign timer_araddr = s_araddr[11:0];
    assign ram_wdata    = s_wdata;
    assign gpio_wdata   = s_wdata;
    assign timer_wdata  = s_wdata;
    assign ram_wstrb    = s_wstrb;
    assign gpio_wstrb   = s_wstrb;
    assign timer_wstrb  = s_wstrb;

    assign ram_awvalid   = s_awvalid & w_idle & (w_sel == soc_pkg::SEL_RAM);
    assign ram_wvalid    = s_wvalid  & w_idle & (w_sel == soc_pkg::SEL_RAM);
    assign gpio_awvalid  = s_awvalid & w_idle & (w_sel == soc_pkg::SEL_GPIO);
    assign gpio_wvalid   = s_wvalid  & w_idle & (w_sel == soc_pkg::SEL_GPIO);
    assign timer_awvalid = s_awvalid & w_idle & (w_sel == soc_pkg::SEL_TIMER);
    assign timer_wvalid  = s_wvalid  & w_idle & (w_sel == soc_pkg::SEL_TIMER);
    assign ram_arvalid   = s_arvalid & r_idle & (r_sel == soc_pkg::SEL_RAM);
    assign gpio_arvalid  = s_arvalid & r_idle & (r_sel == soc_pkg::SEL_GPIO);
    assign timer_arvalid = s_arvalid & r_idle & (r_sel == soc_pkg::SEL_TIMER);

    always_comb begin
        case (w_sel)
            soc_pkg::SEL_RAM: begin
                s_awready = ram_awready;
                s_wready  = ram_wready;
            end
            soc_pkg::SEL_GPIO: begin
                s_awready = gpio_awready;
                s_wready  = gpio_wready;
            end
            soc_pkg::SEL_TIMER: begin
                s_awready = timer_awready;
                s_wready  = timer_wready;
            end
            // Unmapped regions are accepted here
            default: begin
                s_awready = s_awvalid & s_wvalid & w_idle;
                s_wready  = s_awvalid & s_wvalid & w_idle;
            end
        endcase
    end

    always_comb begin
        case (r_sel)
            soc_pkg::SEL_RAM:   s_arready = ram_arready;
            soc_pkg::SEL_GPIO:  s_arready = gpio_arready;
            soc_pkg::SEL_TIMER: s_arready = timer_arready;
            default:            s_arready = s_arvalid & r_idle;
        endcase
    end

    // ==========================================================
    // Responses routed by the selection latched at acceptance
    // ==========================================================
    assign ram_bready   = s_bready & (w_sel_q == soc_pkg::SEL_RAM);
    assign gpio_bready  = s_bready & (w_sel_q == soc_pkg::SEL_GPIO);
    assign timer_bready = s_bready & (w_sel_q == soc_pkg::SEL_TIMER);
    assign ram_rready   = s_rready & (r_sel_q == soc_pkg::SEL_RAM);
    assign gpio_rready  = s_rready & (r_sel_q == soc_pkg::SEL_GPIO);
    assign timer_rready = s_rready & (r_sel_q == soc_pkg::SEL_TIMER);

    always_comb begin
        s_bresp = `AXI_RESP_OKAY;
        case (w_sel_q)
            soc_pkg::SEL_RAM:   s_bvalid = ram_bvalid;
            soc_pkg::SEL_GPIO:  s_bvalid = gpio_bvalid;
            soc_pkg::SEL_TIMER: s_bvalid = timer_bvalid;
            default: begin
                s_bvalid = !w_idle;
                s_bresp  = `AXI_RESP_DECERR;
            end
        endcase
    end

    always_comb begin
        s_rresp = `AXI_RESP_OKAY;
        case (r_sel_q)
            soc_pkg::SEL_RAM: begin
                s_rvalid = ram_rvalid;
                s_rdata  = ram_rdata;
            end
            soc_pkg::SEL_GPIO: begin
                s_rvalid = gpio_rvalid;
                s_rdata  = gpio_rdata;
            end
            soc_pkg::SEL_TIMER: begin
                s_rvalid = timer_rvalid;
                s_rdata  = timer_rdata;
            end
            default: begin
                s_rvalid = !r_idle;
                s_rdata  = '0;
                s_rresp  = `AXI_RESP_DECERR;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_state <= soc_pkg::RESP_IDLE;
            r_state <= soc_pkg::RESP_IDLE;
            w_sel_q <= soc_pkg::SEL_NONE;
            r_sel_q <= soc_pkg::SEL_NONE;
        end else begin
            if (s_awvalid && s_awready) begin
                w_state <= soc_pkg::RESP_PEND;
                w_sel_q <= w_sel;
            end else if (s_bvalid && s_bready) begin
                w_state <= soc_pkg::RESP_IDLE;
            end
            if (s_arvalid && s_arready) begin
                r_state <= soc_pkg::RESP_PEND;
                r_sel_q <= r_sel;
            end else if (s_rvalid && s_rready) begin
                r_state <= soc_pkg::RESP_IDLE;
            end
        end
    end

    a_bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
        s_bvalid && !s_bready |=> s_bvalid);

endmodule

// File: design/axi_ram.sv
`include "soc_settings.svh"

module axi_ram (
    input  logic                  clk,
    input  logic                  rst_n,
    input  soc_pkg::periph_addr_t ram_awaddr, ram_araddr,
    input  soc_pkg::data_t        ram_wdata,
    input  soc_pkg::strb_t        ram_wstrb,
    input  logic                  ram_awvalid, ram_wvalid, ram_bready, ram_arvalid, ram_rready,
    output logic                  ram_awready, ram_wready, ram_bvalid, ram_arready, ram_rvalid,
    output soc_pkg::data_t        ram_rdata
);

    localparam int IDX_W = $clog2(`SOC_RAM_WORDS);

    soc_pkg::data_t       mem [`SOC_RAM_WORDS];
    soc_pkg::resp_state_t b_state, r_state;
    logic                 w_go, r_go;
    logic [IDX_W-1:0]     w_idx, r_idx;

    // Word index sits above the byte lane and upper offset bits alias
    assign w_idx = ram_awaddr[2 +: IDX_W];
    assign r_idx = ram_araddr[2 +: IDX_W];

    assign w_go        = ram_awvalid & ram_wvalid & (b_state == soc_pkg::RESP_IDLE);
    assign r_go        = ram_arvalid & (r_state == soc_pkg::RESP_IDLE);
    assign ram_awready = w_go;
    assign ram_wready  = w_go;
    assign ram_arready = r_go;
    assign ram_bvalid  = (b_state == soc_pkg::RESP_PEND);
    assign ram_rvalid  = (r_state == soc_pkg::RESP_PEND);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b_state <= soc_pkg::RESP_IDLE;
            r_state <= soc_pkg::RESP_IDLE;
        end else begin
            if (w_go)
                b_state <= soc_pkg::RESP_PEND;
            else if (ram_bvalid && ram_bready)
                b_state <= soc_pkg::RESP_IDLE;
            if (r_go)
                r_state <= soc_pkg::RESP_PEND;
            else if (ram_rvalid && ram_rready)
                r_state <= soc_pkg::RESP_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (w_go) begin
            for (int i = 0; i < 4; i++) begin
                if (ram_wstrb[i])
                    mem[w_idx][8*i +: 8] <= ram_wdata[8*i +: 8];
            end
        end
        if (r_go)
            ram_rdata <= mem[r_idx];
    end

    a_rdata_held: assert property (@(posedge clk) disable iff (!rst_n)
        ram_rvalid && !ram_rready |=> ram_rvalid && $stable(ram_rdata));

endmodule

// File: design/axi_gpio.sv
module axi_gpio (
    input  logic                  clk,
    input  logic                  rst_n,
    input  soc_pkg::periph_addr_t gpio_awaddr, gpio_araddr,
    input  soc_pkg::data_t        gpio_wdata,
    input  soc_pkg::strb_t        gpio_wstrb,
    input  logic                  gpio_awvalid, gpio_wvalid, gpio_bready, gpio_arvalid, gpio_rready,
    output logic                  gpio_awready, gpio_wready, gpio_bvalid, gpio_arready, gpio_rvalid,
    output soc_pkg::data_t        gpio_rdata,
    output soc_pkg::data_t        gpio_out
);

    soc_pkg::resp_state_t b_state, r_state;
    logic                 w_go, r_go;

    assign w_go         = gpio_awvalid & gpio_wvalid & (b_state == soc_pkg::RESP_IDLE);
    assign r_go         = gpio_arvalid & (r_state == soc_pkg::RESP_IDLE);
    assign gpio_awready = w_go;
    assign gpio_wready  = w_go;
    assign gpio_arready = r_go;
    assign gpio_bvalid  = (b_state == soc_pkg::RESP_PEND);
    assign gpio_rvalid  = (r_state == soc_pkg::RESP_PEND);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b_state  <= soc_pkg::RESP_IDLE;
            r_state  <= soc_pkg::RESP_IDLE;
            gpio_out <= '0;
        end else begin
            if (w_go)
                b_state <= soc_pkg::RESP_PEND;
            else if (gpio_bvalid && gpio_bready)
                b_state <= soc_pkg::RESP_IDLE;
            if (r_go)
                r_state <= soc_pkg::RESP_PEND;
            else if (gpio_rvalid && gpio_rready)
                r_state <= soc_pkg::RESP_IDLE;
            // Output register lives at word 0 only
            if (w_go && gpio_awaddr[11:2] == '0) begin
                for (int i = 0; i < 4; i++) begin
                    if (gpio_wstrb[i])
                        gpio_out[8*i +: 8] <= gpio_wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (r_go)
            gpio_rdata <= (gpio_araddr[11:2] == '0) ? gpio_out : '0;
    end

endmodule

// File: design/axi_timer.sv
`include "soc_settings.svh"

module axi_timer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  soc_pkg::periph_addr_t timer_awaddr, timer_araddr,
    input  soc_pkg::data_t        timer_wdata,
    input  soc_pkg::strb_t        timer_wstrb,
    input  logic                  timer_awvalid, timer_wvalid, timer_bready,
    input  logic                  timer_arvalid, timer_rready,
    output logic                  timer_awready, timer_wready, timer_bvalid,
    output logic                  timer_arready, timer_rvalid,
    output soc_pkg::data_t        timer_rdata,
    output logic                  timer_irq
);

    soc_pkg::resp_state_t b_state, r_state;
    logic                 w_go, r_go, reg_wr;
    // Bit 0 count enable, bit 1 interrupt enable
    logic [1:0]           ctrl;
    soc_pkg::data_t       limit, count;
    logic                 flag;

    assign w_go          = timer_awvalid & timer_wvalid & (b_state == soc_pkg::RESP_IDLE);
    assign r_go          = timer_arvalid & (r_state == soc_pkg::RESP_IDLE);
    assign timer_awready = w_go;
    assign timer_wready  = w_go;
    assign timer_arready = r_go;
    assign timer_bvalid  = (b_state == soc_pkg::RESP_PEND);
    assign timer_rvalid  = (r_state == soc_pkg::RESP_PEND);

    // Any strobe commits the full word
    assign reg_wr    = w_go & (|timer_wstrb);
    assign timer_irq = flag & ctrl[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b_state <= soc_pkg::RESP_IDLE;
            r_state <= soc_pkg::RESP_IDLE;
        end else begin
            if (w_go)
                b_state <= soc_pkg::RESP_PEND;
            else if (timer_bvalid && timer_bready)
                b_state <= soc_pkg::RESP_IDLE;
            if (r_go)
                r_state <= soc_pkg::RESP_PEND;
            else if (timer_rvalid && timer_rready)
                r_state <= soc_pkg::RESP_IDLE;
        end
    end

    // ==========================================================
    // Counter and registers
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl  <= '0;
            limit <= '0;
            count <= '0;
            flag  <= 1'b0;
        end else begin
            if (ctrl[0]) begin
                if (count == limit) begin
                    count <= '0;
                    flag  <= 1'b1;
                end else begin
                    count <= count + 32'd1;
                end
            end
            // Bus writes take priority over the counter
            if (reg_wr) begin
                case (timer_awaddr)
                    `TIMER_CTRL:   ctrl  <= timer_wdata[1:0];
                    `TIMER_LIMIT:  limit <= timer_wdata;
                    `TIMER_COUNT:  count <= timer_wdata;
                    `TIMER_STATUS: if (timer_wdata[0]) flag <= 1'b0;
                    default:       ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (r_go) begin
            case (timer_araddr)
                `TIMER_CTRL:   timer_rdata <= {30'd0, ctrl};
                `TIMER_LIMIT:  timer_rdata <= limit;
                `TIMER_COUNT:  timer_rdata <= count;
                `TIMER_STATUS: timer_rdata <= {31'd0, flag};
                default:       timer_rdata <= '0;
            endcase
        end
    end

    a_irq_needs_enable: assert property (@(posedge clk) disable iff (!rst_n)
        reg_wr && timer_awaddr == `TIMER_CTRL && !timer_wdata[1] |=> !timer_irq);

endmodule

// File: design/soc_top.sv
module soc_top (
    input  logic           clk,
    input  logic           rst_n,

    input  soc_pkg::addr_t s_awaddr,
    input  logic           s_awvalid,
    output logic           s_awready,
    input  soc_pkg::data_t s_wdata,
    input  soc_pkg::strb_t s_wstrb,
    input  logic           s_wvalid,
    output logic           s_wready,
    output soc_pkg::resp_t s_bresp,
    output logic           s_bvalid,
    input  logic           s_bready,
    input  soc_pkg::addr_t s_araddr,
    input  logic           s_arvalid,
    output logic           s_arready,
    output soc_pkg::data_t s_rdata,
    output soc_pkg::resp_t s_rresp,
    output logic           s_rvalid,
    input  logic           s_rready,

    output soc_pkg::data_t gpio_out,
    output logic           timer_irq
);

    // Interconnect to slave channels
    soc_pkg::periph_addr_t ram_awaddr, ram_araddr;
    soc_pkg::periph_addr_t gpio_awaddr, gpio_araddr;
    soc_pkg::periph_addr_t timer_awaddr, timer_araddr;
    soc_pkg::data_t        ram_wdata, ram_rdata;
    soc_pkg::data_t        gpio_wdata, gpio_rdata;
    soc_pkg::data_t        timer_wdata, timer_rdata;
    soc_pkg::strb_t        ram_wstrb, gpio_wstrb, timer_wstrb;

    logic ram_awvalid, ram_awready, ram_wvalid, ram_wready, ram_bvalid;
    logic ram_bready, ram_arvalid, ram_arready, ram_rvalid, ram_rready;
    logic gpio_awvalid, gpio_awready, gpio_wvalid, gpio_wready, gpio_bvalid;
    logic gpio_bready, gpio_arvalid, gpio_arready, gpio_rvalid, gpio_rready;
    logic timer_awvalid, timer_awready, timer_wvalid, timer_wready, timer_bvalid;
    logic timer_bready, timer_arvalid, timer_arready, timer_rvalid, timer_rready;

    // Port names match the nets above
    axi_interconnect u_interconnect (.*);

    axi_ram u_ram (.*);

    axi_gpio u_gpio (.*);

    axi_timer u_timer (.*);

endmodule

// File: sim/soc_tb.sv
`include "soc_settings.svh"

module soc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD      = 20;
    localparam int SETTLE      = 5;
    localparam int N_RAND      = 16;
    localparam int N_STRB      = 4;
    localparam int N_GPIO      = 4;
    localparam int LIMIT_VALUE = 5;
    localparam int HOLD_CYCLES = 4;

    // Worst case per access is about three cycles so four leaves room
    localparam int ACCESS_CYCLES = 4;
    localparam int N_ACCESSES    = 2*N_RAND + 3*N_STRB + 2*N_GPIO + 1 + 4
                                 + 4*LIMIT_VALUE + 11 + 2*(HOLD_CYCLES + 4);
    localparam int TIMEOUT_NS    = 2 * (3 + N_ACCESSES*ACCESS_CYCLES) * PERIOD;

    localparam soc_pkg::addr_t GPIO_BASE  = {`SOC_REGION_GPIO, 28'd0};
    localparam soc_pkg::addr_t TIMER_BASE = {`SOC_REGION_TIMER, 28'd0};
    localparam soc_pkg::addr_t BAD_BASE   = {4'h5, 28'd0};

    logic           clk = 1'b0;
    logic           rst_n;
    soc_pkg::addr_t s_awaddr, s_araddr;
    soc_pkg::data_t s_wdata, s_rdata, gpio_out;
    soc_pkg::strb_t s_wstrb;
    soc_pkg::resp_t s_bresp, s_rresp;
    logic           s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
    logic           s_arvalid, s_arready, s_rvalid, s_rready, timer_irq;

    soc_pkg::data_t ram_model [`SOC_RAM_WORDS];
    logic [31:0]    lfsr_state = 32'h55b5;

    soc_top uut (.*);

    always #(PERIOD/2) clk = ~clk;

    // ==========================================================
    // Helpers
    // ==========================================================
    function automatic soc_pkg::data_t random_bits(input int n);
        soc_pkg::data_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'hA300_0000 : 32'h0);
        end
        return v;
    endfunction

    function automatic soc_pkg::data_t merge_lanes(input soc_pkg::data_t old_word,
                                                   input soc_pkg::data_t new_word,
                                                   input soc_pkg::strb_t strb);
        soc_pkg::data_t v;
        v = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                v[8*i +: 8] = new_word[8*i +: 8];
        end
        return v;
    endfunction

    function automatic soc_pkg::addr_t ram_addr(input int idx);
        return {`SOC_REGION_RAM, 16'd0, idx[9:0], 2'b00};
    endfunction

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_mismatch(input string what);
        stop_with_failure($sformatf("Mismatch at %0d ns: %s", $time, what));
    endtask

    task automatic check_value(input soc_pkg::data_t got, input soc_pkg::data_t expected,
                               input string what);
        assert (got === expected) else
            report_mismatch($sformatf("%s got %h, expected %h", what, got, expected));
    endtask

    task automatic check_resp(input soc_pkg::resp_t got, input soc_pkg::resp_t expected,
                              input string what);
        assert (got === expected) else
            report_mismatch($sformatf("%s got %0d, expected %0d", what, got, expected));
    endtask

    // ==========================================================
    // Bus master
    // ==========================================================
    task automatic axi_write(input soc_pkg::addr_t addr, input soc_pkg::data_t data,
                             input soc_pkg::strb_t strb, output soc_pkg::resp_t resp);
        @(negedge clk);
        s_awaddr  = addr;
        s_wdata   = data;
        s_wstrb   = strb;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        s_bready  = 1'b1;
        #SETTLE;
        while (!(s_awready && s_wready)) begin
            @(negedge clk);
            #SETTLE;
        end
        assert (!s_bvalid) else report_mismatch("bvalid high before the write was accepted");
        @(negedge clk);
        assert (s_bvalid && !s_awready) else
            report_mismatch("bvalid not raised one cycle after the write was accepted");
        resp      = s_bresp;
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
    endtask

    task automatic axi_read(input soc_pkg::addr_t addr, output soc_pkg::data_t data,
                            output soc_pkg::resp_t resp);
        @(negedge clk);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        s_rready  = 1'b1;
        #SETTLE;
        while (!s_arready) begin
            @(negedge clk);
            #SETTLE;
        end
        assert (!s_rvalid) else report_mismatch("rvalid high before the read was accepted");
        @(negedge clk);
        assert (s_rvalid && !s_arready) else
            report_mismatch("rvalid not raised one cycle after the read was accepted");
        data      = s_rdata;
        resp      = s_rresp;
        s_arvalid = 1'b0;
    endtask

    task automatic ram_store(input int idx, input soc_pkg::data_t data,
                             input soc_pkg::strb_t strb);
        soc_pkg::resp_t resp;
        axi_write(ram_addr(idx), data, strb, resp);
        check_resp(resp, `AXI_RESP_OKAY, "RAM write response");
        ram_model[idx] = merge_lanes(ram_model[idx], data, strb);
    endtask

    task automatic ram_compare(input int idx);
        soc_pkg::data_t data;
        soc_pkg::resp_t resp;
        axi_read(ram_addr(idx), data, resp);
        check_resp(resp, `AXI_RESP_OKAY, "RAM read response");
        check_value(data, ram_model[idx], $sformatf("RAM word %0d", idx));
    endtask

    task automatic timer_write(input soc_pkg::periph_addr_t offset, input soc_pkg::data_t data);
        soc_pkg::resp_t resp;
        axi_write(TIMER_BASE | 32'(offset), data, 4'hF, resp);
        check_resp(resp, `AXI_RESP_OKAY, "timer write response");
    endtask

    task automatic timer_read(input soc_pkg::periph_addr_t offset, output soc_pkg::data_t data);
        soc_pkg::resp_t resp;
        axi_read(TIMER_BASE | 32'(offset), data, resp);
        check_resp(resp, `AXI_RESP_OKAY, "timer read response");
    endtask

    // Poll STATUS until the expiry flag shows up
    task automatic wait_for_flag(input logic irq_enabled);
        soc_pkg::data_t status;
        int             polls;
        status = '0;
        polls  = 0;
        while (!status[0] && polls < 2*LIMIT_VALUE) begin
            timer_read(`TIMER_STATUS, status);
            if (!irq_enabled) begin
                assert (!timer_irq) else
                    report_mismatch("timer_irq high with the interrupt enable cleared");
            end
            polls++;
        end
        assert (status[0]) else
            stop_with_failure("Timer STATUS flag did not set within the poll limit");
    endtask

    // ==========================================================
    // Tests
    // ==========================================================
    task automatic reset_check();
        assert (!s_awready && !s_wready && !s_bvalid && !s_arready && !s_rvalid) else
            report_mismatch("a ready or valid output is high after reset");
        check_value(gpio_out, '0, "gpio_out after reset");
        assert (!timer_irq) else report_mismatch("timer_irq high after reset");
    endtask

    task automatic ram_data_test();
        int idx_list [N_RAND];
        for (int i = 0; i < N_RAND; i++) begin
            idx_list[i] = int'(random_bits(10));
            ram_store(idx_list[i], random_bits(32), 4'hF);
        end
        for (int i = 0; i < N_RAND; i++)
            ram_compare(idx_list[i]);
    endtask

    task automatic ram_strobe_test();
        soc_pkg::strb_t patterns [N_STRB] = '{4'b0001, 4'b0110, 4'b1010, 4'b1000};
        for (int i = 0; i < N_STRB; i++) begin
            ram_store(100 + i, random_bits(32), 4'hF);
            ram_store(100 + i, random_bits(32), patterns[i]);
            ram_compare(100 + i);
        end
    endtask

    task automatic gpio_test();
        soc_pkg::data_t expected, data, rdata;
        soc_pkg::strb_t strb;
        soc_pkg::resp_t resp;
        expected = '0;
        for (int i = 0; i < N_GPIO; i++) begin
            data     = random_bits(32);
            strb     = 4'(random_bits(4));
            expected = merge_lanes(expected, data, strb);
            axi_write(GPIO_BASE, data, strb, resp);
            check_resp(resp, `AXI_RESP_OKAY, "GPIO write response");
            check_value(gpio_out, expected, "gpio_out after write");
            axi_read(GPIO_BASE, rdata, resp);
            check_resp(resp, `AXI_RESP_OKAY, "GPIO read response");
            check_value(rdata, expected, "GPIO read back");
        end
        axi_read(GPIO_BASE + 32'h4, rdata, resp);
        check_resp(resp, `AXI_RESP_OKAY, "GPIO offset 4 response");
        check_value(rdata, '0, "GPIO read at offset 4");
    endtask

    task automatic decode_error_test();
        soc_pkg::data_t rdata;
        soc_pkg::resp_t resp;
        axi_write(BAD_BASE + 32'h10, 32'hDEAD_BEEF, 4'hF, resp);
        check_resp(resp, `AXI_RESP_DECERR, "write to region 5");
        axi_read(BAD_BASE + 32'h10, rdata, resp);
        check_resp(resp, `AXI_RESP_DECERR, "read from region 5");
        check_value(rdata, '0, "rdata from region 5");
        ram_store(7, random_bits(32), 4'hF);
        ram_compare(7);
    endtask

    task automatic timer_irq_test();
        soc_pkg::data_t rdata, first;
        timer_read(`TIMER_COUNT, rdata);
        check_value(rdata, '0, "COUNT after reset");
        timer_read(`TIMER_CTRL, rdata);
        check_value(rdata, '0, "CTRL after reset");
        timer_write(`TIMER_LIMIT, 32'(LIMIT_VALUE));
        timer_write(`TIMER_CTRL, 32'h3);
        wait_for_flag(1'b1);
        assert (timer_irq) else report_mismatch("timer_irq low while flag and enable are set");
        timer_write(`TIMER_STATUS, 32'h1);
        assert (!timer_irq) else report_mismatch("timer_irq still high after the flag was cleared");
        timer_write(`TIMER_CTRL, 32'h0);
        timer_read(`TIMER_COUNT, first);
        timer_read(`TIMER_COUNT, rdata);
        check_value(rdata, first, "COUNT after disable");
        // Counting with the interrupt masked
        timer_write(`TIMER_CTRL, 32'h1);
        wait_for_flag(1'b0);
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            assert (!timer_irq) else report_mismatch("timer_irq high while masked");
        end
        timer_write(`TIMER_CTRL, 32'h0);
        timer_write(`TIMER_STATUS, 32'h1);
    endtask

    task automatic backpressure_test();
        soc_pkg::data_t held_data;
        soc_pkg::resp_t held_resp;
        // Write response held while a second write waits
        @(negedge clk);
        s_awaddr       = ram_addr(200);
        s_wdata        = random_bits(32);
        s_wstrb        = 4'hF;
        s_awvalid      = 1'b1;
        s_wvalid       = 1'b1;
        s_bready       = 1'b0;
        ram_model[200] = s_wdata;
        #SETTLE;
        assert (s_awready && s_wready) else stop_with_failure("Idle RAM did not accept a write");
        @(negedge clk);
        assert (s_bvalid) else report_mismatch("bvalid not raised one cycle after accept");
        held_resp      = s_bresp;
        check_resp(held_resp, `AXI_RESP_OKAY, "held write response");
        s_awaddr       = ram_addr(201);
        s_wdata        = random_bits(32);
        ram_model[201] = s_wdata;
        repeat (HOLD_CYCLES) begin
            #SETTLE;
            assert (!s_awready && !s_wready) else
                report_mismatch("second write accepted while bvalid was held");
            @(negedge clk);
            assert (s_bvalid && s_bresp === held_resp) else
                report_mismatch("write response changed while bready was low");
        end
        s_bready = 1'b1;
        @(negedge clk);
        #SETTLE;
        assert (s_awready && s_wready) else
            stop_with_failure("Second write was not accepted after the response completed");
        @(negedge clk);
        assert (s_bvalid) else report_mismatch("bvalid not raised for the second write");
        check_resp(s_bresp, `AXI_RESP_OKAY, "second write response");
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;

        // Read response held while a second read waits
        @(negedge clk);
        s_araddr  = ram_addr(200);
        s_arvalid = 1'b1;
        s_rready  = 1'b0;
        #SETTLE;
        assert (s_arready) else stop_with_failure("Idle RAM did not accept a read");
        @(negedge clk);
        assert (s_rvalid) else report_mismatch("rvalid not raised one cycle after accept");
        held_data = s_rdata;
        held_resp = s_rresp;
        check_value(held_data, ram_model[200], "held read data");
        s_araddr  = ram_addr(201);
        repeat (HOLD_CYCLES) begin
            #SETTLE;
            assert (!s_arready) else report_mismatch("second read accepted while rvalid was held");
            @(negedge clk);
            assert (s_rvalid && s_rdata === held_data && s_rresp === held_resp) else
                report_mismatch("read response changed while rready was low");
        end
        s_rready = 1'b1;
        @(negedge clk);
        #SETTLE;
        assert (s_arready) else
            stop_with_failure("Second read was not accepted after the response completed");
        @(negedge clk);
        assert (s_rvalid) else report_mismatch("rvalid not raised for the second read");
        check_value(s_rdata, ram_model[201], "second read data");
        s_arvalid = 1'b0;
    endtask

    // ==========================================================
    // Sequence and watchdog
    // ==========================================================
    initial begin
        rst_n     = 1'b0;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_check();
        ram_data_test();
        ram_strobe_test();
        gpio_test();
        decode_error_test();
        timer_irq_test();
        backpressure_test();

        @(negedge clk);
        $display("** PASS **");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: flist.f
+incdir+include
design/soc_pkg.sv
design/axi_interconnect.sv
design/axi_ram.sv
design/axi_gpio.sv
design/axi_timer.sv
design/soc_top.sv
sim/soc_tb.sv

// File: Makefile
FLIST = flist.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f $(FLIST) --top-module soc_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f $(FLIST) --top-module soc_tb -Mdir obj_dir
	./obj_dir/Vsoc_tb | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
